//--- design/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// returned to the host on a get-id frame
`define BOARD_CORE_TYPE 8'ha4

`define STATUS_W 32
`define DAC_W 8

// odd-line dimming, colour minus colour >> shift
`define DIM25_SHIFT 2
`define DIM50_SHIFT 1

`endif

//--- design/host_pkg.sv
package host_pkg;

	// opcodes sent by the host in the first byte of a frame
	typedef enum logic [7:0] {
		CMD_GET_ID = 8'h00,
		CMD_BUT_SW = 8'h01,
		CMD_KBD    = 8'h05,
		CMD_STATUS = 8'h1e,
		CMD_NONE   = 8'hff   // anything we do not handle
	} host_cmd_e;

	// status word bits
	localparam int ST_RESET   = 0;
	localparam int ST_TEST    = 1;
	localparam int ST_SCAN_LO = 3;
	localparam int ST_SCAN_HI = 4;
	localparam int ST_RESET2  = 6;

	// button/switch byte, switches sit in [3:2] and are not used here
	localparam int BS_BTN_RESET  = 1;
	localparam int BS_SD_DISABLE = 4;

	// ps/2 prefixes
	localparam logic [7:0] KBD_BREAK = 8'hf0;
	localparam logic [7:0] KBD_EXT   = 8'he0;

	localparam int KJ_W = 10;
	localparam logic [3:0] KJ_RIGHT  = 4'd0;
	localparam logic [3:0] KJ_LEFT   = 4'd1;
	localparam logic [3:0] KJ_DOWN   = 4'd2;
	localparam logic [3:0] KJ_UP     = 4'd3;
	localparam logic [3:0] KJ_SERVE  = 4'd4;
	localparam logic [3:0] KJ_START1 = 4'd5;
	localparam logic [3:0] KJ_START2 = 4'd6;
	localparam logic [3:0] KJ_COIN   = 4'd7;
	localparam logic [3:0] KJ_ESC    = 4'd8;
	localparam logic [3:0] KJ_ENTER  = 4'd9;

endpackage

//--- design/av_pkg.sv
package av_pkg;

	// scandoubler effect, straight from status[4:3]
	typedef enum logic [1:0] {
		SCAN_NONE  = 2'd0,
		SCAN_HQ2X  = 2'd1,   // decoded only, no filter behind it
		SCAN_CRT25 = 2'd2,
		SCAN_CRT50 = 2'd3
	} scan_mode_e;

	typedef logic [5:0] colour_t;   // one vga channel

endpackage

//--- design/host_bus.sv
`timescale 1ns/1ps

interface host_bus;
	import host_pkg::*;

	host_cmd_e  cmd;      // opcode of the current frame
	logic [7:0] data;
	logic [1:0] index;    // byte number after the opcode
	logic       strobe;   // one cycle per data byte

	modport talker (
		output cmd,
		output data,
		output index,
		output strobe
	);

	modport listener (
		input cmd,
		input data,
		input index,
		input strobe
	);

endinterface

//--- design/host_spi.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module host_spi (
	input  logic    clk_48,
	input  logic    rst_n,
	input  logic    spi_sck,
	input  logic    spi_di,
	input  logic    conf_data0,
	output logic    spi_do,
	host_bus.talker bus
);
	import host_pkg::*;

	localparam logic [7:0] CORE_ID = `BOARD_CORE_TYPE;

	logic [2:0] sck_q;   // [2] is last cycle's synced value
	logic [1:0] di_q;
	logic [1:0] ss_q;
	logic       sck_rise;
	logic       sck_fall;
	logic       active;
	logic [2:0] bit_cnt;
	logic [6:0] sreg;
	logic [7:0] rx_byte;
	logic       got_op;
	logic       byte_done;

	function automatic host_cmd_e decode(input logic [7:0] op);
		case (op)
			CMD_GET_ID, CMD_BUT_SW, CMD_KBD, CMD_STATUS: return host_cmd_e'(op);
			default: return CMD_NONE;
		endcase
	endfunction

	assign sck_rise  = sck_q[1] & ~sck_q[2];
	assign sck_fall  = ~sck_q[1] & sck_q[2];
	assign active    = ~ss_q[1];
	assign rx_byte   = {sreg, di_q[1]};
	assign byte_done = active & sck_rise & (bit_cnt == 3'd7);

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			sck_q <= '0;
			di_q  <= '0;
			ss_q  <= 2'b11;   // frame idle
		end else begin
			sck_q <= {sck_q[1:0], spi_sck};
			di_q  <= {di_q[0], spi_di};
			ss_q  <= {ss_q[0], conf_data0};
		end
	end

	always_ff @(posedge clk_48) begin
		if (sck_rise)
			sreg <= rx_byte[6:0];
		if (byte_done)
			bus.data <= rx_byte;
	end

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			got_op     <= 1'b0;
			bus.cmd    <= CMD_NONE;
			bus.index  <= '0;
			bus.strobe <= 1'b0;
			spi_do     <= 1'b0;
		end else begin
			bus.strobe <= byte_done & got_op;   // opcode byte gives no strobe
			if (!active) begin
				bit_cnt   <= '0;
				got_op    <= 1'b0;
				bus.index <= '0;
				spi_do    <= 1'b0;
			end else begin
				if (bus.strobe)
					bus.index <= bus.index + 2'd1;
				if (sck_rise) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7 && !got_op) begin
						bus.cmd <= decode(rx_byte);
						got_op  <= 1'b1;
					end
				end
				// bit_cnt already points at the next bit, msb first
				if (sck_fall)
					spi_do <= (got_op && bus.cmd == CMD_GET_ID) ? CORE_ID[~bit_cnt] : 1'b0;
			end
		end
	end

	a_strobe_single: assert property (@(posedge clk_48) disable iff (!rst_n)
		bus.strobe |=> !bus.strobe);

endmodule

//--- design/config_regs.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module config_regs (
	input  logic               clk_48,
	input  logic               rst_n,
	host_bus.listener          bus,
	output logic               core_reset_n,
	output logic               test_n,
	output av_pkg::scan_mode_e scan_mode,
	output logic               scandoubler_disable
);
	import host_pkg::*;
	import av_pkg::*;

	logic [`STATUS_W-1:0] status;
	logic [`STATUS_W-9:0] shadow;   // bytes 0..2 wait here for byte 3
	logic                 btn_reset;
	logic [1:0]           status_idx;   // index due on the next status byte
	logic                 status_wr;
	logic                 but_sw_wr;

	assign status_wr = bus.strobe && bus.cmd == CMD_STATUS;
	assign but_sw_wr = bus.strobe && bus.cmd == CMD_BUT_SW;

	always_ff @(posedge clk_48) begin
		if (status_wr && bus.index != 2'd3)
			shadow[{bus.index, 3'b000} +: 8] <= bus.data;
	end

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			status              <= '0;
			btn_reset           <= 1'b0;
			scandoubler_disable <= 1'b0;
			status_idx          <= '0;
		end else begin
			if (status_wr)
				status_idx <= bus.index + 2'd1;
			if (status_wr && bus.index == 2'd3)
				status <= {bus.data, shadow};   // lsb byte came first
			if (but_sw_wr) begin
				btn_reset           <= bus.data[BS_BTN_RESET];
				scandoubler_disable <= bus.data[BS_SD_DISABLE];
			end
		end
	end

	assign core_reset_n = ~(status[ST_RESET] | status[ST_RESET2] | btn_reset);
	assign test_n       = ~status[ST_TEST];
	assign scan_mode    = scan_mode_e'(status[ST_SCAN_HI:ST_SCAN_LO]);

	// status bytes arrive in index order
	a_status_index: assert property (@(posedge clk_48) disable iff (!rst_n)
		status_wr |-> bus.index == status_idx);

endmodule

//--- design/kbd_joy.sv
`timescale 1ns/1ps

module kbd_joy (
	input  logic                   clk_48,
	input  logic                   rst_n,
	host_bus.listener              bus,
	output logic [host_pkg::KJ_W-1:0] kbjoy
);
	import host_pkg::*;

	logic       brk_pend;   // F0 seen
	logic       ext_pend;   // E0 seen
	logic       key_hit;
	logic [3:0] key_bit;
	logic       kbd_wr;

	assign kbd_wr = bus.strobe && bus.cmd == CMD_KBD;

	always_comb begin
		key_hit = 1'b1;
		key_bit = '0;
		case ({ext_pend, bus.data})
			{1'b0, 8'h29}: key_bit = KJ_SERVE;    // space
			{1'b0, 8'h16}: key_bit = KJ_START1;   // 1
			{1'b0, 8'h1e}: key_bit = KJ_START2;   // 2
			{1'b0, 8'h2e}: key_bit = KJ_COIN;     // 5
			{1'b0, 8'h76}: key_bit = KJ_ESC;
			{1'b0, 8'h5a}: key_bit = KJ_ENTER;
			{1'b1, 8'h74}: key_bit = KJ_RIGHT;
			{1'b1, 8'h6b}: key_bit = KJ_LEFT;
			{1'b1, 8'h72}: key_bit = KJ_DOWN;
			{1'b1, 8'h75}: key_bit = KJ_UP;
			default: key_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			brk_pend <= 1'b0;
			ext_pend <= 1'b0;
			kbjoy    <= '0;
		end else if (kbd_wr) begin
			if (bus.data == KBD_BREAK) begin
				brk_pend <= 1'b1;
			end else if (bus.data == KBD_EXT) begin
				ext_pend <= 1'b1;
			end else begin
				if (key_hit)
					kbjoy[key_bit] <= ~brk_pend;   // make sets, break clears
				brk_pend <= 1'b0;
				ext_pend <= 1'b0;
			end
		end
	end

endmodule

//--- design/sigma_dac.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module sigma_dac (
	input  logic              clk_48,
	input  logic              rst_n,
	input  logic [`DAC_W-1:0] audio_in,
	output logic              audio_out
);

	logic [`DAC_W:0] acc;   // msb is the carry of the last add

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= {1'b0, acc[`DAC_W-1:0]} + {1'b0, audio_in};
			audio_out <= acc[`DAC_W];
		end
	end

endmodule

//--- design/video_out.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module video_out (
	input  logic               clk_48,
	input  logic               rst_n,
	input  logic               video_in,
	input  logic               hs_in,
	input  logic               vs_in,
	input  logic               hb_in,
	input  logic               vb_in,
	input  av_pkg::scan_mode_e scan_mode,
	input  logic               scandoubler_disable,
	output av_pkg::colour_t    vga_r,
	output av_pkg::colour_t    vga_g,
	output av_pkg::colour_t    vga_b,
	output logic               vga_hs,
	output logic               vga_vs
);
	import av_pkg::*;

	logic    hs_d;
	logic    vs_d;
	logic    odd_line;
	logic    dim;
	colour_t full;
	colour_t level;
	colour_t rgb_q;   // mono, all channels equal

	assign full = video_in ? colour_t'(6'd63) : colour_t'(6'd0);
	assign dim  = odd_line & ~scandoubler_disable;

	always_comb begin
		case (scan_mode)
			SCAN_CRT25: level = dim ? full - (full >> `DIM25_SHIFT) : full;
			SCAN_CRT50: level = dim ? full - (full >> `DIM50_SHIFT) : full;
			default:    level = full;   // none and hq2x pass through
		endcase
		if (hb_in | vb_in)
			level = '0;
	end

	always_ff @(posedge clk_48 or negedge rst_n) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			odd_line <= 1'b0;
			rgb_q    <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else begin
			hs_d <= hs_in;
			vs_d <= vs_in;
			if (vs_in & ~vs_d)
				odd_line <= 1'b0;   // new frame starts even
			else if (hs_in & ~hs_d)
				odd_line <= ~odd_line;
			rgb_q  <= level;
			vga_hs <= hs_in;
			vga_vs <= vs_in;
		end
	end

	assign vga_r = rgb_q;
	assign vga_g = rgb_q;
	assign vga_b = rgb_q;

	a_blank_black: assert property (@(posedge clk_48) disable iff (!rst_n)
		(hb_in || vb_in) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0));

endmodule

//--- design/board_shell.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module board_shell (
	input  logic              clk_48,
	input  logic              rst_n,
	input  logic              spi_sck,
	input  logic              spi_di,
	input  logic              conf_data0,
	output logic              spi_do,
	input  logic              video_in,
	input  logic              hs_in,
	input  logic              vs_in,
	input  logic              hb_in,
	input  logic              vb_in,
	input  logic [`DAC_W-1:0] audio_in,
	input  logic              lamp1_n,
	output logic [5:0]        vga_r,
	output logic [5:0]        vga_g,
	output logic [5:0]        vga_b,
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              audio_l,
	output logic              audio_r,
	output logic              led,
	output logic              core_reset_n,
	output logic              test_n,
	output logic              coin1_n,
	output logic              coin2_n,
	output logic              start1_n,
	output logic              start2_n,
	output logic              serve_n
);
	import host_pkg::*;
	import av_pkg::*;

	scan_mode_e      scan_mode;
	logic            sd_disable;
	logic [KJ_W-1:0] kbjoy;

	host_bus bus ();

	host_spi u_spi (
		.clk_48(clk_48),
		.rst_n(rst_n),
		.spi_sck(spi_sck),
		.spi_di(spi_di),
		.conf_data0(conf_data0),
		.spi_do(spi_do),
		.bus(bus.talker)
	);

	config_regs u_cfg (
		.clk_48(clk_48),
		.rst_n(rst_n),
		.bus(bus.listener),
		.core_reset_n(core_reset_n),
		.test_n(test_n),
		.scan_mode(scan_mode),
		.scandoubler_disable(sd_disable)
	);

	kbd_joy u_kbd (
		.clk_48(clk_48),
		.rst_n(rst_n),
		.bus(bus.listener),
		.kbjoy(kbjoy)
	);

	sigma_dac u_dac (
		.clk_48(clk_48),
		.rst_n(rst_n),
		.audio_in(audio_in),
		.audio_out(audio_l)
	);

	video_out u_video (
		.clk_48(clk_48),
		.rst_n(rst_n),
		.video_in(video_in),
		.hs_in(hs_in),
		.vs_in(vs_in),
		.hb_in(hb_in),
		.vb_in(vb_in),
		.scan_mode(scan_mode),
		.scandoubler_disable(sd_disable),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	assign audio_r = audio_l;   // mono game
	assign led     = ~lamp1_n;

	// core controls are active low
	assign coin1_n  = ~kbjoy[KJ_COIN];
	assign coin2_n  = ~kbjoy[KJ_COIN];
	assign start1_n = ~kbjoy[KJ_START1];
	assign start2_n = ~kbjoy[KJ_START2];
	assign serve_n  = ~kbjoy[KJ_SERVE];

endmodule

//--- test/tb_board_shell.sv
`timescale 1ns/1ps
`include "board_cfg.svh"

module tb_board_shell;
	import host_pkg::*;

	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] data;   // first data byte in [7:0]
		logic [2:0]  len;
		logic [7:0]  ctl;    // reset, test, coin1, coin2, start1, start2, serve, up
		logic [5:0]  odd;    // colour on an odd line
	} step_t;

	logic       clk_48, rst_n;
	logic       spi_sck, spi_di, conf_data0, spi_do;
	logic       video_in, hs_in, vs_in, hb_in, vb_in;
	logic [7:0] audio_in;
	logic       lamp1_n, led;
	logic [5:0] vga_r, vga_g, vga_b;
	logic       vga_hs, vga_vs, audio_l, audio_r;
	logic       core_reset_n, test_n, coin1_n, coin2_n, start1_n, start2_n, serve_n;

	step_t      steps[$];
	string      names[$];
	int         cycles = 0;
	int         cycle_limit;
	int         ones;
	int         i;
	int         k;
	integer     seed;
	logic [7:0] rx;

	board_shell uut (.*);

	initial begin
		clk_48 = 1'b0;
		forever #20 clk_48 = ~clk_48;
	end

	always @(posedge clk_48) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic tick(input int n);
		repeat (n) @(negedge clk_48);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected %0h actual %0h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_step(input string name, input logic [7:0] op, input logic [31:0] data,
			input logic [2:0] len, input logic [7:0] ctl, input logic [5:0] odd);
		steps.push_back(step_t'{op, data, len, ctl, odd});
		names.push_back(name);
	endtask

	function automatic logic [31:0] ctl_state();
		return 32'({core_reset_n, test_n, coin1_n, coin2_n, start1_n, start2_n, serve_n,
			uut.kbjoy[KJ_UP]});
	endfunction

	// mode 0 host sending msb first and taking spi_do just before each rising sck
	task automatic send_frame(input logic [7:0] op, input logic [31:0] data,
			input logic [2:0] len, output logic [7:0] rx_byte);
		logic [39:0] bytes;
		int          n;
		int          b;
		bytes = {data, op};
		rx_byte = '0;
		conf_data0 = 1'b0;
		tick(4);
		for (n = 0; n <= int'(len); n++) begin
			for (b = 7; b >= 0; b--) begin
				spi_sck = 1'b0;
				spi_di  = bytes[8 * n + b];
				tick(4);
				spi_sck = 1'b1;
				rx_byte = {rx_byte[6:0], spi_do};
				tick(4);
			end
		end
		spi_sck = 1'b0;
		tick(4);
		conf_data0 = 1'b1;
	endtask

	// new frame with one even line, one odd line and two blanked cycles
	task automatic check_video(input string name, input logic [5:0] odd_level);
		vs_in = 1'b1;
		tick(1);
		check_value({name, " vsync"}, 32'b01, 32'({vga_hs, vga_vs}));
		vs_in = 1'b0;
		tick(1);
		check_value({name, " even"}, 32'({3{6'd63}}), 32'({vga_r, vga_g, vga_b}));
		hs_in = 1'b1;
		tick(1);
		check_value({name, " hsync"}, 32'b10, 32'({vga_hs, vga_vs}));
		hs_in = 1'b0;
		tick(1);
		check_value({name, " odd"}, 32'({3{odd_level}}), 32'({vga_r, vga_g, vga_b}));
		hb_in = 1'b1;
		tick(1);
		hb_in = 1'b0;
		check_value({name, " hblank"}, 32'd0, 32'({vga_r, vga_g, vga_b}));
		vb_in = 1'b1;
		tick(1);
		vb_in = 1'b0;
		check_value({name, " vblank"}, 32'd0, 32'({vga_r, vga_g, vga_b}));
	endtask

	initial begin
		seed       = 32'hd054;
		rst_n      = 1'b0;
		spi_sck    = 1'b0;
		spi_di     = 1'b0;
		conf_data0 = 1'b1;
		video_in   = 1'b1;
		hs_in      = 1'b0;
		vs_in      = 1'b0;
		hb_in      = 1'b0;
		vb_in      = 1'b0;
		audio_in   = 8'd0;
		lamp1_n    = 1'b0;

		add_step("status_reset", CMD_STATUS, 32'h0000_0001, 3'd4, 8'b0111_1110, 6'd63);
		add_step("status_reset2_test", CMD_STATUS, 32'h0000_0042, 3'd4, 8'b0011_1110, 6'd63);
		add_step("status_crt25", CMD_STATUS, 32'h5a00_0010, 3'd4, 8'b1111_1110, 6'd48);
		add_step("button_reset", CMD_BUT_SW, 32'h0000_0002, 3'd1, 8'b0111_1110, 6'd48);
		add_step("sd_disable", CMD_BUT_SW, 32'h0000_0010, 3'd1, 8'b1111_1110, 6'd63);
		add_step("sd_enable", CMD_BUT_SW, 32'h0000_0000, 3'd1, 8'b1111_1110, 6'd48);
		add_step("status_crt50", CMD_STATUS, 32'hc3a5_0018, 3'd4, 8'b1111_1110, 6'd32);
		add_step("status_hq2x", CMD_STATUS, 32'h0000_0008, 3'd4, 8'b1111_1110, 6'd63);
		add_step("kbd_coin", CMD_KBD, 32'h0000_002e, 3'd1, 8'b1100_1110, 6'd63);
		add_step("kbd_coin_break", CMD_KBD, 32'h0000_2ef0, 3'd2, 8'b1111_1110, 6'd63);
		add_step("kbd_press", CMD_KBD, 32'h0029_1e16, 3'd3, 8'b1111_0000, 6'd63);
		add_step("kbd_release", CMD_KBD, 32'h1ef0_16f0, 3'd4, 8'b1111_1100, 6'd63);
		add_step("kbd_bare_75", CMD_KBD, 32'h0000_0075, 3'd1, 8'b1111_1100, 6'd63);
		add_step("kbd_ext_up", CMD_KBD, 32'h0000_75e0, 3'd2, 8'b1111_1101, 6'd63);
		add_step("kbd_ext_break", CMD_KBD, 32'h0075_f0e0, 3'd3, 8'b1111_1100, 6'd63);
		add_step("get_id", CMD_GET_ID, 32'h0000_0000, 3'd1, 8'b1111_1100, 6'd63);
		cycle_limit = 2 * (steps.size() * 5 * 8 * 8 + 4 * 256 + 2000);

		tick(2);
		rst_n = 1'b1;
		tick(1);
		check_value("reset controls", 32'(8'b1111_1110), ctl_state());
		check_value("led", 32'd1, 32'(led));
		lamp1_n = 1'b1;
		tick(1);
		check_value("led off", 32'd0, 32'(led));
		check_video("reset", 6'd63);

		for (i = 0; i < steps.size(); i++) begin
			send_frame(steps[i].op, steps[i].data, steps[i].len, rx);
			tick(16);
			check_value(names[i], 32'(steps[i].ctl), ctl_state());
			check_value({names[i], " spi_do"},
				(steps[i].op == CMD_GET_ID) ? 32'(`BOARD_CORE_TYPE) : 32'd0, 32'(rx));
			check_video(names[i], steps[i].odd);
		end

		// the first add after reset shows on the pin two cycles later
		for (k = 0; k < 4; k++) begin
			audio_in = (k == 0) ? 8'd0 : (k == 1) ? 8'd255 : 8'($random(seed));
			rst_n = 1'b0;
			tick(2);
			rst_n = 1'b1;
			tick(1);
			ones = 0;
			repeat (256) begin
				tick(1);
				ones = ones + int'(audio_l);
				check_value("audio_r", 32'(audio_l), 32'(audio_r));
			end
			check_value("audio ones", 32'(audio_in), 32'(ones));
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- files.f
+incdir+design
design/host_pkg.sv
design/av_pkg.sv
design/host_bus.sv
design/host_spi.sv
design/config_regs.sv
design/kbd_joy.sv
design/sigma_dac.sv
design/video_out.sv
design/board_shell.sv
test/tb_board_shell.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_board_shell
FILELIST = files.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the pipeline status is grep's, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F -x '>>> PASS'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
